// File: flist.f
logic/conv_pkg.sv
logic/tile_if.sv
logic/read_requester.sv
logic/tile_store.sv
logic/mac_engine.sv
logic/write_requester.sv
logic/conv_layer_top.sv
verif/tb_clock.sv
verif/mem_model.sv
verif/conv_tb.sv

// File: logic/conv_layer_top.sv
// convolution core top level
// read requester, tile store, MAC engine and write requester
module conv_layer_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  conv_pkg::mem_addr_t  image_addr,
  input  conv_pkg::mem_addr_t  kernel_addr,
  input  conv_pkg::mem_addr_t  dest_addr,
  input  conv_pkg::map_count_t num_in_maps,
  input  conv_pkg::map_count_t num_out_maps,
  output conv_pkg::mem_addr_t  rd_req_addr,
  output conv_pkg::mdata_t     rd_req_mdata,
  output logic                 rd_req_en,
  input  logic                 rd_req_almostfull,
  input  logic                 rd_rsp_valid,
  input  conv_pkg::mdata_t     rd_rsp_mdata,
  input  conv_pkg::line_t      rd_rsp_data,
  output conv_pkg::mem_addr_t  wr_req_addr,
  output conv_pkg::result_t    wr_req_data,
  output logic                 wr_req_en,
  input  logic                 wr_req_almostfull,
  output logic                 done
);
  import conv_pkg::*;

  logic       claim;
  logic       claim_bank;
  logic [1:0] bank_vacant;
  logic       result_valid;
  result_t    result;
  logic       fifo_room;

  tile_if tile ();

  read_requester rd_req0 (
    .clk, .reset, .start, .image_addr, .kernel_addr, .num_in_maps, .num_out_maps,
    .rd_req_almostfull, .bank_vacant, .rd_req_addr, .rd_req_mdata, .rd_req_en,
    .claim, .claim_bank
  );

  tile_store store0 (
    .clk, .reset, .start, .num_in_maps, .rd_rsp_valid, .rd_rsp_mdata, .rd_rsp_data,
    .claim, .claim_bank, .bank_vacant, .t(tile.store)
  );

  mac_engine mac0 (
    .clk, .reset, .num_in_maps, .fifo_room, .result_valid, .result, .t(tile.engine)
  );

  write_requester wr_req0 (
    .clk, .reset, .start, .dest_addr, .num_out_maps, .result_valid, .result,
    .wr_req_almostfull, .fifo_room, .wr_req_addr, .wr_req_data, .wr_req_en, .done
  );

endmodule

// File: logic/conv_pkg.sv
// shared widths, vector types and state encodings for the convolution core
// line_t   lane k real in [32k+15:32k], imag in [32k+31:32k+16]
// result_t lane k real in [64k+31:64k], imag in [64k+63:64k+32]
// mdata_t  bit 7 kind, bit 6 kernel bank, bits 3..0 line index
package conv_pkg;

  localparam int LANES      = 4;
  localparam int SAMPLE_W   = 16;
  localparam int ACC_W      = 32;
  localparam int MAX_MAPS   = 16;
  localparam int INDEX_W    = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int ADDR_W     = 58;
  localparam int MDATA_W    = 8;

  // value of the kind bit in the read tag
  localparam logic KIND_IMAGE  = 1'b0;
  localparam logic KIND_KERNEL = 1'b1;

  typedef logic [ADDR_W-1:0]               mem_addr_t;
  typedef logic [MDATA_W-1:0]              mdata_t;
  typedef logic [LANES*2*SAMPLE_W-1:0]     line_t;
  typedef logic [LANES*2*ACC_W-1:0]        result_t;
  typedef logic [INDEX_W:0]                map_count_t;
  typedef logic [INDEX_W-1:0]              map_index_t;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_IMAGE,
    RD_KERNEL_WAIT,
    RD_KERNEL,
    RD_DONE
  } rd_state_t;

  typedef enum logic [1:0] {
    VACANT,
    FILL,
    FULL,
    DRAIN
  } bank_state_t;

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_RUN,
    EXEC_FLUSH
  } exec_state_t;

endpackage

// File: logic/mac_engine.sv
// MAC engine
// exec FSM that takes full kernel banks in turn and sweeps the line index
// pipeline: memory read, lane-wise complex product, accumulate over D1
// one result line and a bank release per drained bank
module mac_engine (
  input  logic                 clk,
  input  logic                 reset,
  input  conv_pkg::map_count_t num_in_maps,
  input  logic                 fifo_room,
  output logic                 result_valid,
  output conv_pkg::result_t    result,
  tile_if.engine               t
);
  import conv_pkg::*;

  exec_state_t state;
  logic        issue;
  logic        issue_last;
  logic        valid_rd, first_rd, last_rd;
  logic        valid_p, first_p, last_p;

  logic signed [ACC_W-1:0] prod_re [LANES];
  logic signed [ACC_W-1:0] prod_im [LANES];
  logic signed [ACC_W-1:0] acc_re [LANES];
  logic signed [ACC_W-1:0] acc_im [LANES];

  assign issue      = (state == EXEC_RUN);
  assign issue_last = issue && ({1'b0, t.rd_index} == num_in_maps - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= EXEC_IDLE;
      t.drain_bank   <= 1'b0;
      t.drain_start  <= 1'b0;
      t.rd_index     <= '0;
      t.bank_release <= 1'b0;
      valid_rd       <= 1'b0;
      first_rd       <= 1'b0;
      last_rd        <= 1'b0;
      valid_p        <= 1'b0;
      first_p        <= 1'b0;
      last_p         <= 1'b0;
      result_valid   <= 1'b0;
    end else begin
      t.drain_start <= 1'b0;
      case (state)
        // wait until the previous result is in the FIFO so that room covers the next one
        EXEC_IDLE: begin
          if (t.image_ready && t.bank_full[t.drain_bank] && fifo_room && !result_valid) begin
            state         <= EXEC_RUN;
            t.rd_index    <= '0;
            t.drain_start <= 1'b1;
          end
        end
        EXEC_RUN: begin
          if (issue_last) begin
            state <= EXEC_FLUSH;
          end else begin
            t.rd_index <= t.rd_index + 1'b1;
          end
        end
        EXEC_FLUSH: begin
          if (valid_p && last_p) begin
            state        <= EXEC_IDLE;
            t.drain_bank <= ~t.drain_bank;
          end
        end
        default: state <= EXEC_IDLE;
      endcase
      valid_rd       <= issue;
      first_rd       <= issue && (t.rd_index == '0);
      last_rd        <= issue_last;
      valid_p        <= valid_rd;
      first_p        <= first_rd;
      last_p         <= last_rd;
      result_valid   <= valid_p && last_p;
      t.bank_release <= valid_p && last_p;
    end
  end

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    logic signed [SAMPLE_W-1:0] ar, ai, br, bi;

    assign ar = t.image_line[2*SAMPLE_W*k +: SAMPLE_W];
    assign ai = t.image_line[2*SAMPLE_W*k+SAMPLE_W +: SAMPLE_W];
    assign br = t.kernel_line[2*SAMPLE_W*k +: SAMPLE_W];
    assign bi = t.kernel_line[2*SAMPLE_W*k+SAMPLE_W +: SAMPLE_W];

    always_ff @(posedge clk) begin
      if (valid_rd) begin
        prod_re[k] <= ar * br - ai * bi;
        prod_im[k] <= ar * bi + ai * br;
      end
      // sums wrap at 32 bits
      if (valid_p) begin
        acc_re[k] <= first_p ? prod_re[k] : acc_re[k] + prod_re[k];
        acc_im[k] <= first_p ? prod_im[k] : acc_im[k] + prod_im[k];
      end
    end
  end

  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      result[2*ACC_W*k +: ACC_W]       = acc_re[k];
      result[2*ACC_W*k+ACC_W +: ACC_W] = acc_im[k];
    end
  end

endmodule

// File: logic/read_requester.sv
// read request FSM
// image phase of D1 lines, then one kernel batch of D1 lines per output map
// kernel batches alternate between the two store banks, bank 0 first after reset
module read_requester (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  conv_pkg::mem_addr_t  image_addr,
  input  conv_pkg::mem_addr_t  kernel_addr,
  input  conv_pkg::map_count_t num_in_maps,
  input  conv_pkg::map_count_t num_out_maps,
  input  logic                 rd_req_almostfull,
  input  logic [1:0]           bank_vacant,
  output conv_pkg::mem_addr_t  rd_req_addr,
  output conv_pkg::mdata_t     rd_req_mdata,
  output logic                 rd_req_en,
  output logic                 claim,
  output logic                 claim_bank
);
  import conv_pkg::*;

  rd_state_t  state;
  map_index_t line_cnt;
  map_index_t map_cnt;
  mem_addr_t  kernel_ptr;
  logic       next_bank;
  logic       last_line;
  logic       last_map;
  logic       issue;

  assign last_line = ({1'b0, line_cnt} == num_in_maps - 1'b1);
  assign last_map  = ({1'b0, map_cnt} == num_out_maps - 1'b1);
  assign issue     = (state == RD_IMAGE || state == RD_KERNEL) && !rd_req_almostfull;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= RD_IDLE;
      rd_req_en <= 1'b0;
      claim     <= 1'b0;
      next_bank <= 1'b0;
      line_cnt  <= '0;
      map_cnt   <= '0;
    end else begin
      rd_req_en <= issue;
      claim     <= 1'b0;
      if (issue) begin
        line_cnt <= last_line ? '0 : line_cnt + 1'b1;
      end
      case (state)
        // the bank turn carries over from the previous run, as in the engine
        RD_IDLE: begin
          if (start) begin
            state    <= RD_IMAGE;
            line_cnt <= '0;
            map_cnt  <= '0;
          end
        end
        RD_IMAGE: begin
          if (issue && last_line) begin
            state <= RD_KERNEL_WAIT;
          end
        end
        // hold until the next bank in turn is free
        RD_KERNEL_WAIT: begin
          if (bank_vacant[next_bank]) begin
            claim <= 1'b1;
            state <= RD_KERNEL;
          end
        end
        RD_KERNEL: begin
          if (issue && last_line) begin
            next_bank <= ~next_bank;
            map_cnt   <= map_cnt + 1'b1;
            state     <= last_map ? RD_DONE : RD_KERNEL_WAIT;
          end
        end
        RD_DONE: state <= RD_IDLE;
        default: state <= RD_IDLE;
      endcase
    end
  end

  // request address, tag and kernel pointer
  always_ff @(posedge clk) begin
    if (state == RD_IDLE && start) begin
      kernel_ptr <= kernel_addr;
    end else if (issue && state == RD_KERNEL) begin
      kernel_ptr <= kernel_ptr + 1'b1;
    end
    if (state == RD_IMAGE) begin
      rd_req_addr  <= image_addr + mem_addr_t'(line_cnt);
      rd_req_mdata <= {KIND_IMAGE, 1'b0, 2'b00, line_cnt};
    end else begin
      rd_req_addr  <= kernel_ptr;
      rd_req_mdata <= {KIND_KERNEL, next_bank, 2'b00, line_cnt};
    end
    if (state == RD_KERNEL_WAIT) begin
      claim_bank <= next_bank;
    end
  end

endmodule

// File: logic/tile_if.sv
// tile_if: link between the tile store and the MAC engine
// bank status, drain selection and the registered memory read data
interface tile_if;
  import conv_pkg::*;

  logic [1:0] bank_full;
  logic       image_ready;
  logic       drain_bank;
  // one-cycle pulse when the engine takes drain_bank
  logic       drain_start;
  map_index_t rd_index;
  line_t      image_line;
  line_t      kernel_line;
  // one-cycle pulse that hands the drained bank back
  logic       bank_release;

  modport store (output bank_full, image_ready, image_line, kernel_line,
                 input  drain_bank, drain_start, rd_index, bank_release);

  modport engine (input  bank_full, image_ready, image_line, kernel_line,
                  output drain_bank, drain_start, rd_index, bank_release);

endinterface

// File: logic/tile_store.sv
// tile store
// response capture and tag decode into the image memory or a kernel bank
// bank status FSMs (vacant, fill, full, drain) and the image ready flag
// registered reads for the MAC engine
module tile_store (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  conv_pkg::map_count_t num_in_maps,
  input  logic                 rd_rsp_valid,
  input  conv_pkg::mdata_t     rd_rsp_mdata,
  input  conv_pkg::line_t      rd_rsp_data,
  input  logic                 claim,
  input  logic                 claim_bank,
  output logic [1:0]           bank_vacant,
  tile_if.store                t
);
  import conv_pkg::*;

  logic        rsp_valid_q;
  mdata_t      rsp_mdata_q;
  line_t       rsp_data_q;
  logic        image_we;
  logic        kernel_we;
  map_count_t  image_cnt;
  bank_state_t bank_st [2];
  map_count_t  fill_cnt [2];

  line_t image_mem [MAX_MAPS];
  // bank 0 in the lower half, bank 1 in the upper half
  line_t kernel_mem [2*MAX_MAPS];

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_rsp_valid;
    end
    rsp_mdata_q <= rd_rsp_mdata;
    rsp_data_q  <= rd_rsp_data;
  end

  assign image_we  = rsp_valid_q && (rsp_mdata_q[7] == KIND_IMAGE);
  assign kernel_we = rsp_valid_q && (rsp_mdata_q[7] == KIND_KERNEL);

  always_ff @(posedge clk) begin
    if (image_we) begin
      image_mem[map_index_t'(rsp_mdata_q[INDEX_W-1:0])] <= rsp_data_q;
    end
    if (kernel_we) begin
      kernel_mem[{rsp_mdata_q[6], rsp_mdata_q[INDEX_W-1:0]}] <= rsp_data_q;
    end
    t.image_line  <= image_mem[t.rd_index];
    t.kernel_line <= kernel_mem[{t.drain_bank, t.rd_index}];
  end

  // image lines arrive in any order, so count them
  always_ff @(posedge clk) begin
    if (reset || start) begin
      image_cnt <= '0;
    end else if (image_we) begin
      image_cnt <= image_cnt + 1'b1;
    end
  end

  assign t.image_ready = (image_cnt == num_in_maps);

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic bank_we;

    assign bank_we = kernel_we && (rsp_mdata_q[6] == 1'(b));

    always_ff @(posedge clk) begin
      if (reset) begin
        bank_st[b]  <= VACANT;
        fill_cnt[b] <= '0;
      end else begin
        case (bank_st[b])
          VACANT: begin
            if (claim && claim_bank == 1'(b)) begin
              bank_st[b]  <= FILL;
              fill_cnt[b] <= '0;
            end
          end
          FILL: begin
            if (bank_we) begin
              fill_cnt[b] <= fill_cnt[b] + 1'b1;
              if (fill_cnt[b] + 1'b1 == num_in_maps) begin
                bank_st[b] <= FULL;
              end
            end
          end
          FULL: begin
            if (t.drain_start && t.drain_bank == 1'(b)) begin
              bank_st[b] <= DRAIN;
            end
          end
          // only one bank drains at a time
          DRAIN: begin
            if (t.bank_release) begin
              bank_st[b] <= VACANT;
            end
          end
          default: bank_st[b] <= VACANT;
        endcase
      end
    end
  end

  assign bank_vacant = {bank_st[1] == VACANT, bank_st[0] == VACANT};
  assign t.bank_full = {bank_st[1] == FULL, bank_st[0] == FULL};

endmodule

// File: logic/write_requester.sv
// write requester
// small output FIFO popped whenever the write channel is not almost full
// consecutive write addresses from the destination base, done after D2 writes
module write_requester (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  conv_pkg::mem_addr_t  dest_addr,
  input  conv_pkg::map_count_t num_out_maps,
  input  logic                 result_valid,
  input  conv_pkg::result_t    result,
  input  logic                 wr_req_almostfull,
  output logic                 fifo_room,
  output conv_pkg::mem_addr_t  wr_req_addr,
  output conv_pkg::result_t    wr_req_data,
  output logic                 wr_req_en,
  output logic                 done
);
  import conv_pkg::*;

  result_t               fifo_mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic                  push;
  logic                  pop;
  mem_addr_t             next_addr;
  map_count_t            wr_cnt;

  assign push      = result_valid;
  assign pop       = (count != '0) && !wr_req_almostfull;
  assign fifo_room = (count < FIFO_DEPTH);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      wr_req_en <= 1'b0;
      wr_cnt    <= '0;
      done      <= 1'b0;
    end else begin
      wr_req_en <= pop;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // done holds until the next start
      if (start) begin
        wr_cnt <= '0;
        done   <= 1'b0;
      end else if (wr_req_en) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt == num_out_maps - 1'b1) begin
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= result;
    end
    if (pop) begin
      wr_req_data <= fifo_mem[rd_ptr];
      wr_req_addr <= next_addr;
    end
    if (start) begin
      next_addr <= dest_addr;
    end else if (pop) begin
      next_addr <= next_addr + 1'b1;
    end
  end

endmodule

// File: verif/conv_tb.sv
// testbench top for the convolution core
// Galois LFSR, reference model of the lane-wise complex sums
// compare tasks, directed tests and the watchdog
module conv_tb;
  import conv_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 4;
  localparam int CYCLES_PER_REQ = 40;
  // sum of D1*(D2+1) over every run below
  localparam int REQ_TOTAL      = 1*2 + 16*6 + 5*5 + 8*7 + 2*4 + 3*8;
  localparam int WATCHDOG_TIME  = (REQ_TOTAL * CYCLES_PER_REQ + 400) * CLK_PERIOD;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic       clk;
  logic       reset = 1'b1;
  logic       start = 1'b0;
  mem_addr_t  image_addr = '0;
  mem_addr_t  kernel_addr = '0;
  mem_addr_t  dest_addr = '0;
  map_count_t num_in_maps = 5'd1;
  map_count_t num_out_maps = 5'd1;
  mem_addr_t  rd_req_addr;
  mdata_t     rd_req_mdata;
  logic       rd_req_en;
  logic       rd_req_almostfull = 1'b0;
  logic       rd_rsp_valid;
  mdata_t     rd_rsp_mdata;
  line_t      rd_rsp_data;
  mem_addr_t  wr_req_addr;
  result_t    wr_req_data;
  logic       wr_req_en;
  logic       wr_req_almostfull = 1'b0;
  logic       done;

  logic [31:0] lfsr_state = 32'h02294694;
  logic [4:0]  rand_bits = '0;
  logic        backpressure_on = 1'b0;
  logic        rd_af_q = 1'b0;
  logic        wr_af_q = 1'b0;
  int          errors = 0;
  int          checks = 0;
  string       test_name = "none";

  tb_clock clk_gen0 (.clk);

  conv_layer_top dut0 (
    .clk, .reset, .start, .image_addr, .kernel_addr, .dest_addr, .num_in_maps,
    .num_out_maps, .rd_req_addr, .rd_req_mdata, .rd_req_en, .rd_req_almostfull,
    .rd_rsp_valid, .rd_rsp_mdata, .rd_rsp_data, .wr_req_addr, .wr_req_data,
    .wr_req_en, .wr_req_almostfull, .done
  );

  mem_model mem0 (
    .clk, .rand_bits, .rd_req_addr, .rd_req_mdata, .rd_req_en, .rd_rsp_valid,
    .rd_rsp_mdata, .rd_rsp_data, .wr_req_addr, .wr_req_data, .wr_req_en
  );

  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic line_t random_line();
    line_t l;
    for (int i = 0; i < 4; i++) begin
      l[32*i +: 32] = take_bits(32);
    end
    return l;
  endfunction

  function automatic logic [9:0] mem_index(input mem_addr_t a);
    return a[9:0];
  endfunction

  // sum over d of image[d] * kernel[o][d], lane by lane, 32-bit wrap
  function automatic result_t expected_sum(input mem_addr_t ib, input mem_addr_t kb,
                                           input int d1, input int o);
    result_t r;
    line_t   a;
    line_t   b;
    int      ar, ai, br, bi, re, im;
    r = '0;
    for (int k = 0; k < LANES; k++) begin
      re = 0;
      im = 0;
      for (int d = 0; d < d1; d++) begin
        a  = mem0.mem[mem_index(ib + mem_addr_t'(d))];
        b  = mem0.mem[mem_index(kb + mem_addr_t'(o * d1 + d))];
        ar = $signed(a[32*k +: 16]);
        ai = $signed(a[32*k+16 +: 16]);
        br = $signed(b[32*k +: 16]);
        bi = $signed(b[32*k+16 +: 16]);
        re = re + ar * br - ai * bi;
        im = im + ar * bi + ai * br;
      end
      r[64*k +: 32]    = re;
      r[64*k+32 +: 32] = im;
    end
    return r;
  endfunction

  task automatic check_addr(input mem_addr_t expected, input mem_addr_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: address expected %h, got %h", test_name, expected, actual);
    end
  endtask

  task automatic check_result(input result_t expected, input result_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: result expected %h, got %h", test_name, expected, actual);
    end
  endtask

  task automatic check_count(input map_count_t expected, input map_count_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: count expected %0d, got %0d", test_name, expected, actual);
    end
  endtask

  task automatic check_tag(input mdata_t expected, input mdata_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: tag expected %h, got %h", test_name, expected, actual);
    end
  endtask

  // sample almostfull as the DUT sees it, then draw new random bits
  always @(posedge clk) begin
    rd_af_q <= rd_req_almostfull;
    wr_af_q <= wr_req_almostfull;
    #1;
    rand_bits = 5'(take_bits(5));
    #1;
    if (backpressure_on) begin
      rd_req_almostfull = lfsr_step();
      wr_req_almostfull = lfsr_step();
    end else begin
      rd_req_almostfull = 1'b0;
      wr_req_almostfull = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (rd_af_q === 1'b1 && rd_req_en === 1'b1) begin
      errors++;
      $display("error %s: read request issued after rd_req_almostfull was high", test_name);
    end
    if (wr_af_q === 1'b1 && wr_req_en === 1'b1) begin
      errors++;
      $display("error %s: write request issued after wr_req_almostfull was high", test_name);
    end
  end

  task automatic do_reset();
    @(posedge clk);
    #2;
    reset = 1'b1;
    start = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  task automatic fill_random(input mem_addr_t base, input int n);
    @(negedge clk);
    for (int i = 0; i < n; i++) begin
      mem0.mem[mem_index(base + mem_addr_t'(i))] = random_line();
    end
  endtask

  // logs are cleared between edges, while no request is in flight
  task automatic start_run(input mem_addr_t ib, kb, db, input map_count_t d1, d2);
    @(posedge clk);
    #5;
    mem0.clear_logs();
    @(posedge clk);
    #2;
    image_addr   = ib;
    kernel_addr  = kb;
    dest_addr    = db;
    num_in_maps  = d1;
    num_out_maps = d2;
    start        = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (done !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (done !== 1'b1) begin
      errors++;
      $display("error %s: done did not rise within %0d cycles", test_name, limit);
    end
  endtask

  task automatic check_writes(input mem_addr_t ib, kb, db, input map_count_t d1, d2);
    check_count(d2, map_count_t'(mem0.wr_count));
    for (int o = 0; o < int'(d2) && o < mem0.wr_count; o++) begin
      check_addr(db + mem_addr_t'(o), mem0.wr_addr_log[o]);
      check_result(expected_sum(ib, kb, int'(d1), o), mem0.wr_data_log[o]);
    end
  endtask

  task automatic run_and_check(input mem_addr_t ib, kb, db, input map_count_t d1, d2);
    start_run(ib, kb, db, d1, d2);
    wait_done(int'(d1) * (int'(d2) + 1) * CYCLES_PER_REQ + 100);
    check_writes(ib, kb, db, d1, d2);
  endtask

  task automatic single_map();
    test_name = "single_map";
    do_reset();
    @(negedge clk);
    // lane 3 in the top word, imag above real
    mem0.mem[mem_index(58'h100)] = 128'h0003_fffe_7fff_8000_0010_0020_ffff_0001;
    mem0.mem[mem_index(58'h200)] = 128'hfffd_0004_8000_8000_0100_ff00_0002_0003;
    run_and_check(58'h100, 58'h200, 58'h3000, 5'd1, 5'd1);
  endtask

  task automatic full_tile();
    test_name = "full_tile";
    do_reset();
    fill_random(58'h2_0000_0040, 16);
    fill_random(58'h1_0000_0200, 16 * 5);
    run_and_check(58'h2_0000_0040, 58'h1_0000_0200, 58'h1_ffff_fffe, 5'd16, 5'd5);
  endtask

  task automatic read_stream();
    mem_addr_t exp_addr;
    mdata_t    exp_tag;
    int        o;
    int        d;
    test_name = "read_stream";
    do_reset();
    fill_random(58'h080, 5);
    fill_random(58'h300, 5 * 4);
    run_and_check(58'h080, 58'h300, 58'h4000, 5'd5, 5'd4);
    checks++;
    if (mem0.rd_count != 5 * 5) begin
      errors++;
      $display("error %s: request total expected %0d, got %0d", test_name, 25, mem0.rd_count);
    end
    for (int i = 0; i < mem0.rd_count && i < 25; i++) begin
      if (i < 5) begin
        exp_addr = 58'h080 + mem_addr_t'(i);
        exp_tag  = {KIND_IMAGE, 1'b0, 2'b00, 4'(i)};
      end else begin
        o        = i / 5 - 1;
        d        = i % 5;
        exp_addr = 58'h300 + mem_addr_t'(o * 5 + d);
        exp_tag  = {KIND_KERNEL, 1'(o % 2), 2'b00, 4'(d)};
      end
      check_addr(exp_addr, mem0.rd_addr_log[i]);
      check_tag(exp_tag, mem0.rd_tag_log[i]);
    end
  endtask

  task automatic backpressure();
    test_name = "backpressure";
    do_reset();
    fill_random(58'h0c0, 8);
    fill_random(58'h100, 8 * 6);
    backpressure_on = 1'b1;
    run_and_check(58'h0c0, 58'h100, 58'h5000, 5'd8, 5'd6);
    backpressure_on = 1'b0;
  endtask

  task automatic done_and_restart();
    test_name = "done_and_restart";
    do_reset();
    @(negedge clk);
    checks++;
    if (done !== 1'b0) begin
      errors++;
      $display("error %s: done is not low after reset", test_name);
    end
    // an odd map count so that the second run begins on bank 1
    fill_random(58'h040, 2);
    fill_random(58'h180, 2 * 3);
    run_and_check(58'h040, 58'h180, 58'h6000, 5'd2, 5'd3);
    // done holds until the next start
    @(negedge clk);
    checks++;
    if (done !== 1'b1) begin
      errors++;
      $display("error %s: done did not stay high after the last write", test_name);
    end
    fill_random(58'h050, 3);
    fill_random(58'h1c0, 3 * 7);
    start_run(58'h050, 58'h1c0, 58'h7000, 5'd3, 5'd7);
    @(negedge clk);
    checks++;
    if (done !== 1'b0) begin
      errors++;
      $display("error %s: done still high after the second start", test_name);
    end
    wait_done(3 * 8 * CYCLES_PER_REQ + 100);
    check_writes(58'h050, 58'h1c0, 58'h7000, 5'd3, 5'd7);
  endtask

  initial begin
    single_map();
    full_tile();
    read_stream();
    backpressure();
    done_and_restart();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog: run not finished after %0d time units, checks %0d, errors %0d",
             WATCHDOG_TIME, checks, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: verif/mem_model.sv
// memory responder for the read and write request channels
// reads come back after a random delay, adjacent ready responses may swap
// read requests and writes are logged for the testbench checks
module mem_model (
  input  logic                clk,
  input  logic [4:0]          rand_bits,
  input  conv_pkg::mem_addr_t rd_req_addr,
  input  conv_pkg::mdata_t    rd_req_mdata,
  input  logic                rd_req_en,
  output logic                rd_rsp_valid,
  output conv_pkg::mdata_t    rd_rsp_mdata,
  output conv_pkg::line_t     rd_rsp_data,
  input  conv_pkg::mem_addr_t wr_req_addr,
  input  conv_pkg::result_t   wr_req_data,
  input  logic                wr_req_en
);
  import conv_pkg::*;

  localparam int MEM_LINES = 1024;
  localparam int LOG_DEPTH = 512;
  localparam int WR_DEPTH  = 64;

  // lines are addressed by the low 10 address bits
  line_t     mem [MEM_LINES];
  mem_addr_t rd_addr_log [LOG_DEPTH];
  mdata_t    rd_tag_log [LOG_DEPTH];
  mem_addr_t wr_addr_log [WR_DEPTH];
  result_t   wr_data_log [WR_DEPTH];
  int        rd_count = 0;
  int        wr_count = 0;
  int        cycle = 0;

  // outstanding reads in request order
  mem_addr_t pend_addr [$];
  mdata_t    pend_tag [$];
  int        pend_due [$];

  task clear_logs();
    rd_count = 0;
    wr_count = 0;
    pend_addr.delete();
    pend_tag.delete();
    pend_due.delete();
  endtask

  // capture requests where the DUT outputs are stable
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (rd_req_en === 1'b1) begin
      pend_addr.push_back(rd_req_addr);
      pend_tag.push_back(rd_req_mdata);
      pend_due.push_back(cycle + 1 + int'(rand_bits[3:0]));
      if (rd_count < LOG_DEPTH) begin
        rd_addr_log[rd_count] = rd_req_addr;
        rd_tag_log[rd_count]  = rd_req_mdata;
      end
      rd_count = rd_count + 1;
    end
    if (wr_req_en === 1'b1) begin
      if (wr_count < WR_DEPTH) begin
        wr_addr_log[wr_count] = wr_req_addr;
        wr_data_log[wr_count] = wr_req_data;
      end
      wr_count = wr_count + 1;
    end
  end

  // at most one response per cycle
  initial begin
    int pick;
    rd_rsp_valid = 1'b0;
    rd_rsp_mdata = '0;
    rd_rsp_data  = '0;
    forever begin
      @(posedge clk);
      #2;
      pick = -1;
      for (int i = 0; i < pend_due.size(); i++) begin
        if (pick < 0 && pend_due[i] <= cycle) begin
          pick = i;
        end
      end
      // swap with the next entry when that one is ready too
      if (pick >= 0 && rand_bits[4] && pick + 1 < pend_due.size()) begin
        if (pend_due[pick+1] <= cycle) begin
          pick = pick + 1;
        end
      end
      if (pick >= 0) begin
        rd_rsp_valid = 1'b1;
        rd_rsp_mdata = pend_tag[pick];
        rd_rsp_data  = mem[pend_addr[pick][9:0]];
        pend_addr.delete(pick);
        pend_tag.delete(pick);
        pend_due.delete(pick);
      end else begin
        rd_rsp_valid = 1'b0;
      end
    end
  end

endmodule

// File: verif/tb_clock.sv
// testbench clock generator, period 20
module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 10;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

endmodule
